// ==== filelist.f ====
logic/kcpu_pkg.sv
logic/kcpu_alu.sv
logic/kcpu_regs.sv
logic/kcpu_memctrl.sv
logic/kcpu_ctrl.sv
logic/kcpu.sv
verification/kcpu_clkgen.sv
verification/kcpu_sva.sv
verification/kcpu_tb.sv

// ==== logic/kcpu.sv ====
// kcpu top level: clock enable generation and block instances
`timescale 1ns/100ps

module kcpu import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cen2,
    output logic  cen_out,

    input  logic  halt,
    input  logic  dtack,

    input  byte_t din,
    output byte_t dout,
    output word_t addr,
    output logic  we,
    output word_t pcbad,
    output logic  buserror
);

    byte_t    op, a, b, cc, cc_out, rslt, st_data;
    word_t    mdata, ea, x, pc;
    alu_sel_t alu_sel;
    logic     fetch, opd, wrq, use_ea;
    logic     up_a, up_b, up_x, up_pc, up_cc, leax, branch, st_b;
    logic     clken, clken2, phase;

    assign cen_out = clken2;

    // Half rate enable, only advances while the bus acknowledges
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= 1'b0;
            clken  <= 1'b0;
            clken2 <= 1'b0;
        end else begin
            if (cen2 && dtack)
                phase <= ~phase;
            clken  <= cen2 & dtack & phase;
            clken2 <= cen2 & dtack;
        end
    end

    kcpu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .cen(clken), .halt(halt),
        .op(op), .cc(cc), .pc(pc),
        .fetch(fetch), .opd(opd), .wrq(wrq), .use_ea(use_ea),
        .up_a(up_a), .up_b(up_b), .up_x(up_x), .up_pc(up_pc), .up_cc(up_cc),
        .leax(leax), .branch(branch), .st_b(st_b), .alu_sel(alu_sel),
        .buserror(buserror), .pcbad(pcbad)
    );

    kcpu_memctrl u_memctrl (
        .clk(clk), .rst_n(rst_n), .cen(clken),
        .fetch(fetch), .opd(opd), .wrq(wrq), .use_ea(use_ea),
        .din(din), .pc(pc), .x(x), .st_data(st_data),
        .addr(addr), .dout(dout), .we(we), .op(op), .mdata(mdata), .ea(ea)
    );

    kcpu_alu u_alu (
        .alu_sel(alu_sel), .opnd0(a), .opnd1(mdata[7:0]),
        .rslt(rslt), .cc_out(cc_out)
    );

    kcpu_regs u_regs (
        .clk(clk), .rst_n(rst_n), .cen(clken),
        .up_a(up_a), .up_b(up_b), .up_x(up_x), .up_pc(up_pc), .up_cc(up_cc),
        .leax(leax), .branch(branch), .st_b(st_b),
        .rslt(rslt), .alu_cc(cc_out), .mdata(mdata), .ea(ea),
        .a(a), .b(b), .x(x), .pc(pc), .cc(cc), .st_data(st_data)
    );

endmodule

// ==== logic/kcpu_alu.sv ====
// kcpu_alu: 8-bit load, add, subtract and logic functions with N, Z, V, C flags
`timescale 1ns/100ps

module kcpu_alu import kcpu_pkg::*; (
    input  alu_sel_t alu_sel,
    input  byte_t    opnd0,     // Accumulator A
    input  byte_t    opnd1,     // Operand byte
    output byte_t    rslt,
    output byte_t    cc_out
);

    logic [8:0] sum, dif;
    logic       v, c, cvld;

    assign sum = {1'b0, opnd0} + {1'b0, opnd1};
    assign dif = {1'b0, opnd0} - {1'b0, opnd1};

    always_comb begin
        rslt = opnd1;
        v    = 1'b0;
        c    = 1'b0;
        cvld = 1'b0;
        case (alu_sel)
            ALU_ADD: begin
                rslt = sum[7:0];
                c    = sum[8];
                cvld = 1'b1;
                // Same operand signs, different result sign
                v    = (opnd0[7] == opnd1[7]) && (sum[7] != opnd0[7]);
            end
            ALU_SUB: begin
                rslt = dif[7:0];
                c    = dif[8];          // Borrow
                cvld = 1'b1;
                v    = (opnd0[7] != opnd1[7]) && (dif[7] != opnd0[7]);
            end
            ALU_AND: rslt = opnd0 & opnd1;
            ALU_OR:  rslt = opnd0 | opnd1;
            ALU_EOR: rslt = opnd0 ^ opnd1;
            default: rslt = opnd1;      // Load
        endcase
    end

    // Logic functions and loads leave C alone, flagged by CC_CVLD low
    always_comb begin
        cc_out          = '0;
        cc_out[CC_N]    = rslt[7];
        cc_out[CC_Z]    = rslt == 8'h00;
        cc_out[CC_V]    = v;
        cc_out[CC_C]    = c;
        cc_out[CC_CVLD] = cvld;
    end

endmodule

// ==== logic/kcpu_ctrl.sv ====
// Instruction sequencer with opcode decode, bus cycle requests and register update strobes
`timescale 1ns/100ps

module kcpu_ctrl import kcpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cen,
    input  logic     halt,
    input  byte_t    op,
    input  byte_t    cc,
    input  word_t    pc,

    output logic     fetch,
    output logic     opd,
    output logic     wrq,
    output logic     use_ea,
    output logic     up_a,
    output logic     up_b,
    output logic     up_x,
    output logic     up_pc,
    output logic     up_cc,
    output logic     leax,
    output logic     branch,
    output logic     st_b,
    output alu_sel_t alu_sel,
    output logic     buserror,
    output word_t    pcbad
);

    ctrl_state_e state, nx_state;
    logic        is_acca, is_ldb, is_ext, is_one, is_br, br_taken, defined;

    // Opcode classes
    always_comb begin
        is_acca = 1'b1;     // Result goes to A through the ALU
        alu_sel = ALU_LD;
        case (op)
            OP_ADDA: alu_sel = ALU_ADD;
            OP_SUBA: alu_sel = ALU_SUB;
            OP_ANDA: alu_sel = ALU_AND;
            OP_ORA:  alu_sel = ALU_OR;
            OP_EORA: alu_sel = ALU_EOR;
            OP_LDA_IMM, OP_LDA_EXT: alu_sel = ALU_LD;
            default: is_acca = 1'b0;
        endcase
    end

    assign is_ldb  = op == OP_LDB_IMM;
    assign is_br   = op == OP_BRA || op == OP_BEQ || op == OP_BNE;
    // Two operand bytes follow the opcode
    assign is_ext  = op == OP_LDA_EXT || op == OP_STA_EXT || op == OP_STB_EXT ||
                     op == OP_LDX_IMM;
    // Exactly one operand byte
    assign is_one  = (is_acca && op != OP_LDA_EXT) || is_ldb || is_br ||
                     op == OP_LEAX || op == OP_STA_IDX;
    assign defined = is_one || is_ext || op == OP_NOP;

    always_comb begin
        case (op)
            OP_BEQ:  br_taken = cc[CC_Z];
            OP_BNE:  br_taken = ~cc[CC_Z];
            default: br_taken = 1'b1;       // BRA
        endcase
    end

    always_comb begin
        nx_state = state;
        case (state)
            ST_FETCH: if (!halt) nx_state = ST_OPD1;
            ST_OPD1: begin
                if (!defined)
                    nx_state = ST_ERROR;
                else if (is_ext)
                    nx_state = ST_OPD2;
                else if (is_one)
                    nx_state = ST_EXEC;     // Indexed store also adds X here
                else
                    nx_state = ST_FETCH;    // NOP
            end
            ST_OPD2: begin
                if (op == OP_LDA_EXT)
                    nx_state = ST_RDMEM;
                else if (op == OP_LDX_IMM)
                    nx_state = ST_EXEC;
                else
                    nx_state = ST_WRITE;
            end
            ST_RDMEM: nx_state = ST_EXEC;
            ST_EXEC:  nx_state = op == OP_STA_IDX ? ST_WRITE : ST_FETCH;
            ST_WRITE: nx_state = ST_FETCH;
            default:  nx_state = ST_ERROR;  // Held until reset
        endcase
    end

    // Bus cycle requests
    assign fetch  = state == ST_FETCH && !halt;
    assign opd    = (state == ST_OPD1 && is_one) || (state == ST_OPD1 && is_ext) ||
                    state == ST_OPD2;
    assign wrq    = state == ST_WRITE;
    assign use_ea = state == ST_RDMEM || state == ST_WRITE;
    assign st_b   = op == OP_STB_EXT;
    assign up_pc  = fetch | opd;       // PC steps past every instruction byte

    // Register strobes last one clken
    assign up_a   = state == ST_EXEC && is_acca;
    assign up_b   = state == ST_EXEC && is_ldb;
    assign up_cc  = state == ST_EXEC && (is_acca || is_ldb);
    assign up_x   = state == ST_EXEC && op == OP_LDX_IMM;
    assign leax   = state == ST_EXEC && op == OP_LEAX;
    assign branch = state == ST_EXEC && is_br && br_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_FETCH;
            buserror <= 1'b0;
            pcbad    <= '0;
        end else if (cen) begin
            state <= nx_state;
            if (state == ST_ERROR && !buserror) begin
                buserror <= 1'b1;
                pcbad    <= pc - 16'd1;    // PC already stepped past the opcode
            end
        end
    end

endmodule

// ==== logic/kcpu_memctrl.sv ====
// kcpu_memctrl: bus address mux, operand assembly, effective address adder, write strobe
`timescale 1ns/100ps

module kcpu_memctrl import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cen,

    input  logic  fetch,
    input  logic  opd,
    input  logic  wrq,
    input  logic  use_ea,

    input  byte_t din,
    input  word_t pc,
    input  word_t x,
    input  byte_t st_data,

    output word_t addr,
    output byte_t dout,
    output logic  we,
    output byte_t op,
    output word_t mdata,      // First operand byte high
    output word_t ea
);

    logic  idx;
    word_t ofs;

    // STA indexed and LEAX both take X plus offset
    assign idx = op == OP_STA_IDX || op == OP_LEAX;
    assign ofs = {{8{mdata[7]}}, mdata[7:0]};
    assign ea  = idx ? x + ofs : mdata;

    // Bus outputs follow the state, steady while the cycle is stretched
    assign addr = use_ea ? ea : pc;
    assign we   = wrq;
    assign dout = wrq ? st_data : 8'h00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            op <= OP_NOP;
        else if (cen && fetch)
            op <= din;
    end

    // Operand bytes and read data shift in from the low end
    always_ff @(posedge clk) begin
        if (cen && (opd || (use_ea && !wrq)))
            mdata <= {mdata[7:0], din};
    end

endmodule

// ==== logic/kcpu_pkg.sv ====
// Width typedefs, opcode and ALU select constants, CC bit positions, controller states
package kcpu_pkg;

    typedef logic [7:0]  byte_t;       // Data byte
    typedef logic [15:0] word_t;       // Address or 16-bit operand
    typedef logic [2:0]  alu_sel_t;    // ALU function select

    // ALU functions
    localparam alu_sel_t ALU_LD  = 3'd0;   // Pass operand 1
    localparam alu_sel_t ALU_ADD = 3'd1;
    localparam alu_sel_t ALU_SUB = 3'd2;
    localparam alu_sel_t ALU_AND = 3'd3;
    localparam alu_sel_t ALU_OR  = 3'd4;
    localparam alu_sel_t ALU_EOR = 3'd5;

    // Loads and stores
    localparam byte_t OP_LDA_IMM = 8'h86;
    localparam byte_t OP_LDB_IMM = 8'hC6;
    localparam byte_t OP_LDA_EXT = 8'hB6;
    localparam byte_t OP_STA_EXT = 8'hB7;
    localparam byte_t OP_STB_EXT = 8'hF7;
    localparam byte_t OP_STA_IDX = 8'hA7;   // Offset from X, signed 8 bits
    localparam byte_t OP_LDX_IMM = 8'h8E;
    localparam byte_t OP_LEAX    = 8'h30;

    // Accumulator A with immediate operand
    localparam byte_t OP_ADDA = 8'h8B;
    localparam byte_t OP_SUBA = 8'h80;
    localparam byte_t OP_ANDA = 8'h84;
    localparam byte_t OP_ORA  = 8'h8A;
    localparam byte_t OP_EORA = 8'h88;

    // Relative branches
    localparam byte_t OP_BRA = 8'h20;
    localparam byte_t OP_BEQ = 8'h27;
    localparam byte_t OP_BNE = 8'h26;

    localparam byte_t OP_NOP = 8'h12;

    // CC bit positions
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    // Set by the ALU on its flag output when C is defined, never stored in CC
    localparam int CC_CVLD = 4;

    typedef enum logic [2:0] {
        ST_FETCH,   // Opcode read
        ST_OPD1,    // Decode, first operand byte
        ST_OPD2,    // Second operand byte
        ST_RDMEM,   // Data read at the effective address
        ST_EXEC,    // Register updates
        ST_WRITE,   // Data write at the effective address
        ST_ERROR    // Undefined opcode, locked
    } ctrl_state_e;

endpackage

// ==== logic/kcpu_regs.sv ====
// kcpu_regs: A, B, X, PC and CC registers with update paths and store data select
`timescale 1ns/100ps

module kcpu_regs import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cen,

    input  logic  up_a,
    input  logic  up_b,
    input  logic  up_x,
    input  logic  up_pc,
    input  logic  up_cc,
    input  logic  leax,
    input  logic  branch,
    input  logic  st_b,

    input  byte_t rslt,
    input  byte_t alu_cc,
    input  word_t mdata,
    input  word_t ea,

    output byte_t a,
    output byte_t b,
    output word_t x,
    output word_t pc,
    output byte_t cc,
    output byte_t st_data
);

    word_t nx_x, br_off;

    assign nx_x    = leax ? ea : mdata;                 // LEAX or LDX
    assign br_off  = {{8{mdata[7]}}, mdata[7:0]};
    assign st_data = st_b ? b : a;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a  <= '0;
            b  <= '0;
            x  <= '0;
            pc <= '0;       // Execution starts at 0000h
            cc <= '0;
        end else if (cen) begin
            if (up_a)
                a <= rslt;
            if (up_b)
                b <= rslt;
            if (up_x || leax) begin
                x        <= nx_x;
                cc[CC_Z] <= nx_x == 16'h0000;
            end
            if (up_cc) begin
                cc[CC_N] <= alu_cc[CC_N];
                cc[CC_Z] <= alu_cc[CC_Z];
                cc[CC_V] <= alu_cc[CC_V];
                if (alu_cc[CC_CVLD])
                    cc[CC_C] <= alu_cc[CC_C];
            end
            // Offset is relative to the byte after the branch
            if (branch)
                pc <= pc + br_off;
            else if (up_pc)
                pc <= pc + 16'd1;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the kcpu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module kcpu_tb -f filelist.f
./obj_dir/Vkcpu_tb | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== verification/kcpu_clkgen.sv ====
// kcpu_clkgen: free running testbench clock, 4 ns period
`timescale 1ns/100ps

module kcpu_clkgen (
    output logic clk
);

    initial clk = 1'b0;
    always #2 clk = ~clk;

endmodule

// ==== verification/kcpu_sva.sv ====
// kcpu_sva: bound assertions on bus write, bus hold and buserror behavior
`timescale 1ns/100ps

module kcpu_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        dtack,
    input logic        we,
    input logic        buserror,
    input logic [15:0] addr
);

    a_no_we_on_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(we && buserror)) else $error("we high while buserror is set");

    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(buserror) |-> buserror) else $error("buserror fell without reset");

    // A low dtack blocks the enable one negedge later, so the bus holds one edge on
    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(dtack, 2) |-> ($stable(addr) && $stable(we)))
        else $error("addr or we moved while dtack was low");

endmodule

// ==== verification/kcpu_tb.sv ====
// Random program generator, memory model with throttling, reference model, checks and watchdog
`timescale 1ns/100ps

module kcpu_tb import kcpu_pkg::*; ();

    localparam int NUM_TESTS = 5;
    localparam int GROUPS = 48;     // Instruction groups per program
    // Up to three instructions per group, 40 clken periods each at a quarter of full rate
    localparam int WATCHDOG_NS = NUM_TESTS * (GROUPS * 3 + 2) * 40 * 32 + 1000;

    logic  clk, rst_n, cen2, dtack, halt, cen_out, we, buserror, prev_we, exp_cen;
    byte_t din, dout;
    word_t addr, pcbad, bad;
    byte_t mem [0:4095];
    byte_t ref_mem [0:4095];
    word_t exp_addr [$];
    byte_t exp_data [$];
    int    seed = 32'hdc5097dd;
    int    errors, writes, mode, t, err0;
    int    modes [NUM_TESTS] = '{0, 1, 2, 4, 7};    // Bit 0 dtack, 1 cen2, 2 halt
    byte_t alu_ops [5] = '{OP_ADDA, OP_SUBA, OP_ANDA, OP_ORA, OP_EORA};

    kcpu_clkgen u_clk (.clk(clk));

    kcpu UUT (
        .clk(clk), .rst_n(rst_n), .cen2(cen2), .cen_out(cen_out), .halt(halt),
        .dtack(dtack), .din(din), .dout(dout), .addr(addr), .we(we),
        .pcbad(pcbad), .buserror(buserror)
    );

    bind kcpu kcpu_sva u_sva (.clk(clk), .rst_n(rst_n), .dtack(dtack), .we(we),
        .buserror(buserror), .addr(addr));

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic put(inout int pc, input byte_t v);
        mem[pc[11:0]] = v;
        pc++;
    endtask

    // Opcode plus a data address in 0800h to 0FFFh
    task automatic put_ext(inout int pc, input byte_t op);
        logic [31:0] r;
        r = rnd();
        put(pc, op);
        put(pc, {5'b00001, r[10:8]});
        put(pc, r[7:0]);
    endtask

    // Groups that leave X alone and so may be skipped by a branch
    task automatic put_group(inout int pc, input int kind);
        logic [31:0] r;
        r = rnd();
        case (kind)
            0: begin
                put(pc, OP_LDA_IMM);
                put(pc, r[7:0]);
                put_ext(pc, OP_STA_EXT);
            end
            1: begin
                put(pc, OP_LDB_IMM);
                put(pc, r[7:0]);
                put_ext(pc, OP_STB_EXT);
            end
            2: begin
                put(pc, alu_ops[int'(r[10:8]) % 5]);
                put(pc, r[7:0]);
                put_ext(pc, OP_STA_EXT);
            end
            default: begin
                put_ext(pc, OP_LDA_EXT);
                put_ext(pc, OP_STA_EXT);
            end
        endcase
    endtask

    task automatic gen_program();
        int          pc, bpc, kind;
        logic [31:0] r;
        word_t       gx;
        byte_t       off;
        for (int a = 0; a < 4096; a++)
            mem[a] = byte_t'(a) ^ byte_t'(a >> 4) ^ 8'h5a;
        pc = 0;
        gx = 16'h0a00;
        put(pc, OP_LDX_IMM);
        put(pc, gx[15:8]);
        put(pc, gx[7:0]);
        for (int g = 0; g < GROUPS; g++) begin
            r = rnd();
            kind = int'(r[2:0]);
            if (kind < 4) begin
                put_group(pc, kind);
            end else if (kind == 4) begin
                gx = {5'b00001, r[13:3]};
                if (gx < 16'h0880)
                    gx = gx + 16'h0080;
                if (gx > 16'h0f7f)
                    gx = gx - 16'h0080;
                put(pc, OP_LDX_IMM);
                put(pc, gx[15:8]);
                put(pc, gx[7:0]);
                put(pc, OP_STA_IDX);
                put(pc, r[31:24]);
            end else if (kind == 5) begin
                off = {3'b000, r[7:3]};
                if (gx > 16'h0c00)
                    off = 8'h00 - off;    // Steer X back toward the middle
                gx = gx + {{8{off[7]}}, off};
                put(pc, OP_LEAX);
                put(pc, off);
                put(pc, OP_STA_IDX);
                put(pc, r[31:24]);
            end else if (kind == 6) begin
                bpc = pc;
                put(pc, r[4:3] == 2'd0 ? OP_BRA : (r[5] ? OP_BEQ : OP_BNE));
                put(pc, 8'h00);
                put_group(pc, int'(r[9:8]));
                mem[bpc + 1] = byte_t'(pc - bpc - 2);
            end else begin
                put(pc, OP_NOP);
            end
        end
        put(pc, 8'h01);     // Undefined opcode ends the program
    endtask

    function automatic byte_t rm(word_t a);
        return ref_mem[a[11:0]];
    endfunction

    task automatic expect_write(input word_t ea, input byte_t v);
        exp_addr.push_back(ea);
        exp_data.push_back(v);
        ref_mem[ea[11:0]] = v;
    endtask

    // Instruction set model that lists the writes and the undefined opcode address
    task automatic run_model(output word_t bad_pc);
        word_t pc, x, ea;
        byte_t a, b, op, o;
        logic  z, done;
        pc = 16'h0000;
        x = 16'h0000;
        a = 8'h00;
        b = 8'h00;
        z = 1'b0;
        done = 1'b0;
        bad_pc = 16'h0000;
        while (!done) begin
            op = rm(pc);
            o = rm(pc + 16'd1);
            ea = {o, rm(pc + 16'd2)};
            pc = pc + 16'd1;
            case (op)
                OP_NOP: ;
                OP_LDA_IMM, OP_LDB_IMM, OP_ADDA, OP_SUBA, OP_ANDA, OP_ORA, OP_EORA: begin
                    pc = pc + 16'd1;
                    case (op)
                        OP_LDB_IMM: b = o;
                        OP_ADDA: a = a + o;
                        OP_SUBA: a = a - o;
                        OP_ANDA: a = a & o;
                        OP_ORA: a = a | o;
                        OP_EORA: a = a ^ o;
                        default: a = o;
                    endcase
                    z = (op == OP_LDB_IMM) ? (b == 8'h00) : (a == 8'h00);
                end
                OP_LDA_EXT, OP_STA_EXT, OP_STB_EXT, OP_LDX_IMM: begin
                    pc = pc + 16'd2;
                    if (op == OP_LDA_EXT) begin
                        a = rm(ea);
                        z = a == 8'h00;
                    end else if (op == OP_LDX_IMM) begin
                        x = ea;
                        z = x == 16'h0000;
                    end else begin
                        expect_write(ea, op == OP_STB_EXT ? b : a);
                    end
                end
                OP_STA_IDX: begin
                    pc = pc + 16'd1;
                    expect_write(x + {{8{o[7]}}, o}, a);
                end
                OP_LEAX: begin
                    pc = pc + 16'd1;
                    x = x + {{8{o[7]}}, o};
                    z = x == 16'h0000;
                end
                OP_BRA, OP_BEQ, OP_BNE: begin
                    pc = pc + 16'd1;
                    if (op == OP_BRA || (op == OP_BEQ) == z)
                        pc = pc + {{8{o[7]}}, o};
                end
                default: begin
                    bad_pc = pc - 16'd1;
                    done = 1'b1;
                end
            endcase
        end
    endtask

    // Memory model, throttling and output checks on the falling edge
    always @(negedge clk) begin
        logic [31:0] r;
        if (modes[0] != mode)
            r = rnd();
        else
            r = 32'hffffffff;
        // cen_out follows the enables seen one falling edge earlier
        if (rst_n)
            compare("cen_out", {15'h0000, cen_out}, {15'h0000, exp_cen});
        exp_cen <= rst_n ? (cen2 && dtack) : 1'b0;
        dtack <= mode[0] ? r[1:0] != 2'd0 : 1'b1;
        cen2 <= mode[1] ? r[3:2] != 2'd0 : 1'b1;
        halt <= mode[2] ? r[6:4] == 3'd0 : 1'b0;
        din <= mem[addr[11:0]];
        prev_we <= rst_n ? we : 1'b0;
        if (rst_n && we && !prev_we) begin
            writes++;
            mem[addr[11:0]] = dout;
            if (exp_addr.size() == 0) begin
                $display("Unexpected write to %h, no more writes were expected", addr);
                errors++;
            end else begin
                compare("addr", addr, exp_addr.pop_front());
                compare("dout", {8'h00, dout}, {8'h00, exp_data.pop_front()});
            end
        end
    end

    initial begin
        rst_n <= 1'b0;
        cen2 <= 1'b0;
        dtack <= 1'b0;
        halt <= 1'b0;
        din <= 8'h00;
        prev_we <= 1'b0;
        exp_cen <= 1'b0;
        errors = 0;
        writes = 0;
        mode = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk) rst_n <= 1'b0;
            @(posedge clk);
            mode = 0;
            err0 = errors;
            exp_addr.delete();
            exp_data.delete();
            gen_program();
            ref_mem = mem;
            run_model(bad);
            @(negedge clk);
            @(posedge clk);
            mode = modes[t];
            @(negedge clk) rst_n <= 1'b1;
            while (!buserror)
                @(negedge clk);
            repeat (40) @(negedge clk);     // Any late write would show here
            compare("pcbad", pcbad, bad);
            if (exp_addr.size() != 0) begin
                $display("Test %0d: %0d expected writes never happened", t, exp_addr.size());
                errors++;
            end
            $display("Test %0d mode %0d: %0s", t, mode, errors == err0 ? "ok" : "failed");
        end
        $display("Tests %0d, writes %0d, errors %0d", NUM_TESTS, writes, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog timeout, the core never reached the closing opcode");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
